/* compile.f */
hw/zports_pkg.sv
hw/port_decode.sv
hw/xt_regs.sv
hw/ide_bridge.sv
hw/port_read_mux.sv
hw/zports_top.sv
test/zports_asserts.sv
test/zports_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --assert --top-module zports_tb -f compile.f -o zports_sim \
	&& ./obj_dir/zports_sim | tee sim.log \
	|| echo "build or simulation stopped with an error"
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/zports_tb.sv */
// testbench for the Z80 port block, runs held bus cycles on zports_top against a register model
`timescale 1ns/1ps
`default_nettype none

module zports_tb;
	import zports_pkg::*;

	typedef struct packed {
		sys_cfg_t  cfg;
		page_vec_t page;
		logic      locked;  // #7FFD bit 5 accepted
		logic      pwr;
		logic      pwr_reg;
		byte_t     hi_in;
		byte_t     hi_out;
	} model_t;

	localparam byte_t xt_index [9] = '{8'h10, 8'h11, 8'h12, 8'h13, 8'h15,
		8'h20, 8'h21, 8'h25, 8'h29};

	logic       zclk;
	logic       rst;
	word_t      a;
	byte_t      din;
	logic       iorq;
	logic       rd;
	logic       wr;
	logic       tape_read;
	logic [4:0] keys_in;
	logic [4:0] kj_in;
	byte_t      mus_in;
	word_t      idein;
	sys_cfg_t   sys_cfg;
	page_vec_t  xt_page;
	byte_t      dout;
	logic       porthit;
	logic       dataout;
	word_t      ideout;
	logic       idedataout;
	logic [2:0] ide_a;
	logic       ide_cs0_n;
	logic       ide_cs1_n;
	logic       ide_rd_n;
	logic       ide_wr_n;

	integer seed;
	model_t model;
	logic   cur_wr;      // last cycle, handed to the checker
	word_t  cur_addr;
	byte_t  cur_data;
	byte_t  obs_dout;
	logic   obs_hit;
	logic   obs_dataout;
	logic   obs_rd_n;
	logic   obs_wr_n;
	word_t  obs_ideout;
	logic [2:0] obs_ide_a;
	logic   obs_cs0_n;
	logic   obs_cs1_n;
	logic   obs_ddir;    // idedataout during the cycle
	byte_t  exp_dout;
	logic   exp_hit;
	event   cycle_done;

	zports_top dut0 (.*);

	initial
	begin
		zclk = 1'b0;
		forever #50 zclk = ~zclk;
	end

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic compare_page(input string name, input page_vec_t got, input page_vec_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic compare_cfg(input string name, input sys_cfg_t got, input sys_cfg_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	// ide register address, a7..a5
	task automatic compare_reg_addr(input string name, input logic [2:0] got,
		input logic [2:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	function automatic logic is_ide_even(word_t addr);
		return addr[7:0] inside {8'h10, 8'h30, 8'h50, 8'h70, 8'h90,
			8'hB0, 8'hD0, 8'hF0, 8'hC8};
	endfunction

	function automatic logic port_claimed(word_t addr);
		if (addr[7:0] == 8'hFD)
			return ~addr[15]; // a15 high belongs to the AY
		return is_ide_even(addr) || (addr[7:0] inside {8'hFE, 8'hAF, 8'h11, 8'h1F, 8'hDF});
	endfunction

	// register model after one completed bus cycle
	function automatic model_t model_step(model_t m, logic is_wr, word_t addr, byte_t data,
		word_t ide_word);
		model_t n;
		logic   lock128;
		n = m;
		lock128 = (m.cfg.memconf[7:6] == 2'b01);
		if (is_wr && addr[7:0] == 8'hFD && !addr[15] && !m.locked)
		begin
			n.cfg.memconf[0] = data[4];
			n.page[31:24] = {3'b000, lock128 ? 2'b00 : data[7:6], data[2:0]};
			n.locked = data[5];
		end
		else if (is_wr && addr[7:0] == 8'hAF)
		begin
			case (addr[15:8])
				8'h10: n.page[7:0] = data;
				8'h11: n.page[15:8] = data;
				8'h12: n.page[23:16] = data;
				8'h13: n.page[31:24] = data;
				8'h15: n.cfg.fmaddr = data[4:0];
				8'h20: n.cfg.sysconf = data;
				8'h21: n.cfg.memconf = data;
				8'h25: n.cfg.im2vect = data;
				8'h29: n.cfg.fddvirt = data[3:0];
				default: ;
			endcase
		end
		else if (!is_wr && addr == 16'h00AF)
		begin
			n.pwr_reg = m.pwr; // xstat read hands the flag over
			n.pwr = 1'b0;
		end
		else if (!is_wr && addr[7:0] == 8'h10)
			n.hi_in = ide_word[15:8];
		else if (is_wr && addr[7:0] == 8'h11)
			n.hi_out = data;
		return n;
	endfunction

	function automatic byte_t expected_dout(model_t m, word_t addr);
		if (is_ide_even(addr))
			return idein[7:0];
		case (addr[7:0])
			8'hFE: return {1'b1, tape_read, 1'b0, keys_in};
			8'h11: return m.hi_in;
			8'h1F: return {3'b000, kj_in};
			8'hDF: return mus_in;
			8'hAF:
			begin
				if (addr[15:8] == 8'h00)
					return {2'b00, m.pwr_reg, 5'b00000};
				if (addr[15:8] == 8'h12)
					return m.page[23:16];
				if (addr[15:8] == 8'h13)
					return m.page[31:24];
				return 8'hFF;
			end
			default: return 8'hFF;
		endcase
	endfunction

	task automatic wait_clocks(input integer count);
		integer n;
		for (n = 0; n < count; n++)
			@(negedge zclk);
	endtask

	// one Z80 cycle held for 4 clocks, then 2 idle clocks
	task automatic bus_cycle(input logic is_wr, input word_t addr, input byte_t data);
		integer n;
		logic   seen;
		a    = addr;
		din  = data;
		iorq = 1'b1;
		rd   = ~is_wr;
		wr   = is_wr;
		seen = 1'b0;
		for (n = 0; n < 8 && !seen; n++)
		begin
			@(negedge zclk);
			seen = is_wr ? dut0.u_decode.strobe.wr : dut0.u_decode.strobe.rd;
		end
		if (!seen)
		begin
			$display("timeout: no strobe for the cycle on port %h", addr);
			$display("sim failed");
			$fatal(1, "bus cycle timed out");
		end
		obs_rd_n    = ide_rd_n;
		obs_wr_n    = ide_wr_n;
		obs_ideout  = ideout;
		obs_hit     = porthit;
		obs_dataout = dataout;
		obs_ide_a   = ide_a;
		obs_cs0_n   = ide_cs0_n;
		obs_cs1_n   = ide_cs1_n;
		obs_ddir    = idedataout;
		wait_clocks(2);
		obs_dout = dout;  // end of cycle
		model    = model_step(model, is_wr, addr, data, idein);
		exp_dout = expected_dout(model, addr);
		exp_hit  = port_claimed(addr);
		cur_wr   = is_wr;
		cur_addr = addr;
		cur_data = data;
		-> cycle_done;
		iorq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
		wait_clocks(2);
	endtask

	always @(cycle_done)
	begin
		compare_page("xt_page", xt_page, model.page);
		compare_cfg("sys_cfg", sys_cfg, model.cfg);
		compare_bit("porthit", obs_hit, exp_hit);
		compare_bit("dataout", obs_dataout, exp_hit & ~cur_wr);
		compare_bit("ide_rd_n", obs_rd_n, ~(~cur_wr & is_ide_even(cur_addr)));
		compare_bit("ide_wr_n", obs_wr_n, ~(cur_wr & is_ide_even(cur_addr)));
		compare_bit("idedataout", obs_ddir, cur_wr & is_ide_even(cur_addr));
		compare_bit("ide_cs1_n", obs_cs1_n, cur_addr[7:0] != 8'hC8);
		compare_bit("ide_cs0_n", obs_cs0_n,
			!(is_ide_even(cur_addr) && cur_addr[7:0] != 8'hC8));
		if (is_ide_even(cur_addr))
			compare_reg_addr("ide_a", obs_ide_a, cur_addr[7:5]);
		if (!cur_wr)
			compare_byte("dout", obs_dout, exp_dout);
		else if (cur_addr[7:0] == 8'h10)
			compare_word("ideout", obs_ideout, {model.hi_out, cur_data});
	end

	initial
	begin
		integer i;
		byte_t  v;
		seed      = 32'h9db0_b592;
		rst       = 1'b1;
		a         = '0;
		din       = '0;
		iorq      = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		tape_read = 1'b0;
		keys_in   = '0;
		kj_in     = '0;
		mus_in    = '0;
		idein     = '0;
		model     = '0;
		model.cfg  = {8'h01, 8'h04, 8'hFF, 5'h00, 4'h0};
		model.page = 32'h0002_0500;
		model.pwr  = 1'b1;
		wait_clocks(5);
		rst = 1'b0;

		compare_page("xt_page", xt_page, 32'h0002_0500);
		compare_cfg("sys_cfg", sys_cfg, {8'h01, 8'h04, 8'hFF, 5'h00, 4'h0});
		compare_bit("strobe.rd", dut0.u_decode.strobe.rd, 1'b0);
		compare_bit("strobe.wr", dut0.u_decode.strobe.wr, 1'b0);
		compare_bit("ide_rd_n", ide_rd_n, 1'b1);
		compare_bit("ide_wr_n", ide_wr_n, 1'b1);
		compare_bit("dataout", dataout, 1'b0);

		// power-up flag, set on the first read only
		bus_cycle(1'b0, 16'h00AF, 8'h00);
		bus_cycle(1'b0, 16'h00AF, 8'h00);

		for (i = 0; i < 9; i++)
			bus_cycle(1'b1, {xt_index[i], 8'hAF}, rand_byte());
		bus_cycle(1'b0, 16'h12AF, 8'h00);
		bus_cycle(1'b0, 16'h13AF, 8'h00);
		bus_cycle(1'b0, 16'h20AF, 8'h00);  // write-only register

		// #7FFD paging, lock128, then lock bit
		bus_cycle(1'b1, 16'h21AF, 8'h04);
		for (i = 0; i < 3; i++)
			bus_cycle(1'b1, 16'h7FFD, rand_byte() & 8'hDF);
		bus_cycle(1'b1, 16'hFFFD, 8'h17);
		bus_cycle(1'b1, 16'h21AF, 8'h44);
		bus_cycle(1'b1, 16'h7FFD, 8'hC3);
		bus_cycle(1'b0, 16'h13AF, 8'h00);
		bus_cycle(1'b1, 16'h21AF, 8'h04);
		bus_cycle(1'b1, 16'h7FFD, 8'h26);
		bus_cycle(1'b1, 16'h7FFD, 8'hD1);

		for (i = 0; i < 4; i++)
		begin
			idein = {rand_byte(), rand_byte()};
			bus_cycle(1'b0, 16'h0010, 8'h00);
			idein = {rand_byte(), rand_byte()}; // high byte must come from the latch
			bus_cycle(1'b0, 16'h0011, 8'h00);
			bus_cycle(1'b0, 16'h00C8, 8'h00);
			bus_cycle(1'b1, 16'h0011, rand_byte());
			bus_cycle(1'b1, 16'h0010, rand_byte());
			compare_bit("ide_wr_n", ide_wr_n, 1'b1);
		end

		for (i = 0; i < 4; i++)
		begin
			v = rand_byte();
			keys_in   = v[4:0];
			tape_read = v[7];
			v = rand_byte();
			kj_in  = v[4:0];
			mus_in = rand_byte();
			bus_cycle(1'b0, {rand_byte(), 8'hFE}, 8'h00);
			bus_cycle(1'b0, 16'h001F, 8'h00);
			bus_cycle(1'b0, 16'h00DF, 8'h00);
			bus_cycle(1'b0, 16'h0005, 8'h00);
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/zports_asserts.sv */
// concurrent checks on bus strobes and IDE control lines, bound into the decoder and IDE bridge
`timescale 1ns/1ps
`default_nettype none

module zports_asserts (
	input wire                         zclk,
	input wire                         rst,
	input wire zports_pkg::io_strobe_t strobe,
	input wire                         ide_rd_n,
	input wire                         ide_wr_n
);

	// one pulse per held bus cycle
	rd_strobe_single: assert property (@(posedge zclk) disable iff (rst)
		strobe.rd |=> !strobe.rd)
		else $error("read strobe high for two cycles running");

	wr_strobe_single: assert property (@(posedge zclk) disable iff (rst)
		strobe.wr |=> !strobe.wr)
		else $error("write strobe high for two cycles running");

	strobe_exclusive: assert property (@(posedge zclk) disable iff (rst)
		!(strobe.rd && strobe.wr))
		else $error("read and write strobes high together");

	// device never sees read and write at once
	ide_exclusive: assert property (@(posedge zclk) disable iff (rst)
		ide_rd_n || ide_wr_n)
		else $error("ide_rd_n and ide_wr_n both low");

endmodule

bind port_decode zports_asserts decode_chk (.zclk(zclk), .rst(rst), .strobe(strobe),
	.ide_rd_n(1'b1), .ide_wr_n(1'b1));

// device side control lines of the bridge
bind ide_bridge zports_asserts ide_chk (.zclk(zclk), .rst(1'b0), .strobe(2'b00),
	.ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n));

`default_nettype wire

/* hw/zports_top.sv */
// top of the Z80 port block, wires the decoder to the register, IDE and read-mux datapaths
`timescale 1ns/1ps
`default_nettype none

module zports_top (
	input  wire                       zclk,
	input  wire                       rst,
	input  wire zports_pkg::word_t    a,
	input  wire zports_pkg::byte_t    din,
	input  wire                       iorq,
	input  wire                       rd,
	input  wire                       wr,
	input  wire                       tape_read,
	input  wire [4:0]                 keys_in,
	input  wire [4:0]                 kj_in,
	input  wire zports_pkg::byte_t    mus_in,
	input  wire zports_pkg::word_t    idein,
	output zports_pkg::sys_cfg_t      sys_cfg,
	output zports_pkg::page_vec_t     xt_page,
	output zports_pkg::byte_t         dout,
	output logic                      porthit,
	output logic                      dataout,
	output zports_pkg::word_t         ideout,
	output logic                      idedataout,
	output logic [2:0]                ide_a,
	output logic                      ide_cs0_n,
	output logic                      ide_cs1_n,
	output logic                      ide_rd_n,
	output logic                      ide_wr_n
);
	import zports_pkg::*;

	io_strobe_t strobe;
	port_sel_t  sel;
	byte_t      status;
	byte_t      ide_hi_byte;

	port_decode u_decode (
		.zclk    (zclk),
		.rst     (rst),
		.a       (a),
		.iorq    (iorq),
		.rd      (rd),
		.wr      (wr),
		.strobe  (strobe),
		.sel     (sel),
		.porthit (porthit),
		.dataout (dataout)
	);

	xt_regs u_xt_regs (
		.zclk    (zclk),
		.rst     (rst),
		.din     (din),
		.hoa     (a[15:8]),  // register index for #nnAF
		.strobe  (strobe),
		.sel     (sel),
		.sys_cfg (sys_cfg),
		.xt_page (xt_page),
		.status  (status)
	);

	ide_bridge u_ide (
		.zclk        (zclk),
		.din         (din),
		.a_low3      (a[7:5]),
		.iorq        (iorq),
		.rd          (rd),
		.wr          (wr),
		.strobe      (strobe),
		.sel         (sel),
		.idein       (idein),
		.ideout      (ideout),
		.ide_hi_byte (ide_hi_byte),
		.ide_a       (ide_a),
		.ide_cs0_n   (ide_cs0_n),
		.ide_cs1_n   (ide_cs1_n),
		.ide_rd_n    (ide_rd_n),
		.ide_wr_n    (ide_wr_n),
		.idedataout  (idedataout)
	);

	port_read_mux u_read_mux (
		.sel         (sel),
		.hoa         (a[15:8]),
		.status      (status),
		.xt_page     (xt_page),
		.ide_hi_byte (ide_hi_byte),
		.idein       (idein),
		.keys_in     (keys_in),
		.tape_read   (tape_read),
		.kj_in       (kj_in),
		.mus_in      (mus_in),
		.dout        (dout)
	);

endmodule

`default_nettype wire

/* hw/port_read_mux.sv */
// read data multiplexer, picks the byte returned to the Z80 for the decoded port
`timescale 1ns/1ps
`default_nettype none

module port_read_mux (
	input  wire zports_pkg::port_sel_t sel,
	input  wire zports_pkg::byte_t     hoa,
	input  wire zports_pkg::byte_t     status,
	input  wire zports_pkg::page_vec_t xt_page,
	input  wire zports_pkg::byte_t     ide_hi_byte,
	input  wire zports_pkg::word_t     idein,
	input  wire [4:0]                  keys_in,
	input  wire                        tape_read,
	input  wire [4:0]                  kj_in,
	input  wire zports_pkg::byte_t     mus_in,
	output zports_pkg::byte_t          dout
);
	import zports_pkg::*;

	byte_t xt_dout;

	// only status and the two upper pages read back through #nnAF
	always_comb
	begin
		case (hoa)
			xstat:
				xt_dout = status;
			rampage_base + 8'd2:
				xt_dout = xt_page[23:16];
			rampage_base + 8'd3:
				xt_dout = xt_page[31:24];
			default:
				xt_dout = 8'hFF;
		endcase
	end

	always_comb
	begin
		if (sel.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.ide_even)
			dout = idein[7:0]; // device low byte, straight through
		else if (sel.ide_odd)
			dout = ide_hi_byte;
		else if (sel.xt)
			dout = xt_dout;
		else if (sel.kjoy)
			dout = {3'b000, kj_in};
		else if (sel.kmouse)
			dout = mus_in;
		else
			dout = 8'hFF; // floating bus
	end

endmodule

`default_nettype wire

/* hw/ide_bridge.sv */
// 16-bit IDE data path in normal mode, #10 carries the low byte and #11 the high byte
`timescale 1ns/1ps
`default_nettype none

module ide_bridge (
	input  wire                         zclk,
	input  wire zports_pkg::byte_t      din,
	input  wire [2:0]                   a_low3,
	input  wire                         iorq,
	input  wire                         rd,
	input  wire                         wr,
	input  wire zports_pkg::io_strobe_t strobe,
	input  wire zports_pkg::port_sel_t  sel,
	input  wire zports_pkg::word_t      idein,
	output zports_pkg::word_t           ideout,
	output zports_pkg::byte_t           ide_hi_byte,
	output logic [2:0]                  ide_a,
	output logic                        ide_cs0_n,
	output logic                        ide_cs1_n,
	output logic                        ide_rd_n,
	output logic                        ide_wr_n,
	output logic                        idedataout
);
	import zports_pkg::*;

	byte_t hi_in;   // high byte of last word read from device
	byte_t hi_out;  // high byte waiting for the #10 write
	logic  data_port;

	// #10 is the only even ide port with a7..a5 all zero
	assign data_port = sel.ide_even & (a_low3 == 3'b000);

	always_ff @(posedge zclk)
	begin
		if (strobe.rd & data_port)
			hi_in <= idein[15:8];
		if (strobe.wr & sel.ide_odd)
			hi_out <= din;
	end

	assign ide_hi_byte = hi_in;
	assign ideout      = {hi_out, din}; // low byte comes live off the bus

	assign ide_a     = a_low3;
	assign ide_cs0_n = ~(sel.ide_even & ~sel.ide_cs1);
	assign ide_cs1_n = ~sel.ide_cs1;

	// #11 is a local latch, it never strobes the device
	assign ide_rd_n = ~(iorq & rd & sel.ide_even);
	assign ide_wr_n = ~(iorq & wr & sel.ide_even);

	assign idedataout = ~ide_wr_n; // bus buffer drives toward device

endmodule

`default_nettype wire

/* hw/xt_regs.sv */
// extended config registers behind #nnAF, the #7FFD paging port and the power-up status flag
`timescale 1ns/1ps
`default_nettype none

module xt_regs (
	input  wire                         zclk,
	input  wire                         rst,
	input  wire zports_pkg::byte_t      din,
	input  wire zports_pkg::byte_t      hoa,
	input  wire zports_pkg::io_strobe_t strobe,
	input  wire zports_pkg::port_sel_t  sel,
	output zports_pkg::sys_cfg_t        sys_cfg,
	output zports_pkg::page_vec_t       xt_page,
	output zports_pkg::byte_t           status
);
	import zports_pkg::*;

	byte_t p7ffd;      // last accepted #7FFD value
	byte_t page3_7ffd; // page 3 as loaded through #7FFD
	logic  xt_wr;
	logic  xstat_rd;
	logic  p7ffd_wr;
	logic  lock128;
	logic  pwr_up;     // set by reset, cleared by first XSTAT read
	logic  pwr_up_reg;

	assign xt_wr    = strobe.wr & sel.xt;
	assign xstat_rd = strobe.rd & sel.xt & (hoa == xstat);

	// bit 5 locks the port until the next reset
	assign p7ffd_wr = strobe.wr & sel.fd & ~p7ffd[5];

	// 128K lock mode hides the upper page bits
	assign lock128 = (sys_cfg.memconf[7:6] == 2'b01);

	assign page3_7ffd = {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			sys_cfg.sysconf <= sysconf_rst;
			sys_cfg.memconf <= memconf_rst;
			sys_cfg.im2vect <= im2vect_rst;
			sys_cfg.fmaddr  <= '0;
			sys_cfg.fddvirt <= '0;
			xt_page         <= {page3_rst, page2_rst, page1_rst, page0_rst};
		end
		else if (p7ffd_wr)
		begin
			sys_cfg.memconf[0] <= din[4]; // rom select
			xt_page[31:24]     <= page3_7ffd;
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == rampage_base[7:2])
				xt_page[{hoa[1:0], 3'b000} +: 8] <= din;
			if (hoa == fmaddr_idx)
				sys_cfg.fmaddr <= din[4:0];
			if (hoa == sysconf_idx)
				sys_cfg.sysconf <= din;
			if (hoa == memconf_idx)
				sys_cfg.memconf <= din;
			if (hoa == im2vect_idx)
				sys_cfg.im2vect <= din;
			if (hoa == fddvirt_idx)
				sys_cfg.fddvirt <= din[3:0];
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst)
			p7ffd <= '0;
		else if (p7ffd_wr)
			p7ffd <= din;
	end

	// status captures the flag on read, so the first read still sees it
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			pwr_up     <= 1'b1;
			pwr_up_reg <= 1'b0;
		end
		else if (xstat_rd)
		begin
			pwr_up_reg <= pwr_up;
			pwr_up     <= 1'b0;
		end
	end

	// dma active and no-ide bits read as 0
	assign status = {2'b00, pwr_up_reg, 5'b00000};

endmodule

`default_nettype wire

/* hw/port_decode.sv */
// bus front end, makes zclk read/write strobes and decodes the low address byte into port classes
`timescale 1ns/1ps
`default_nettype none

module port_decode (
	input  wire                       zclk,
	input  wire                       rst,
	input  wire zports_pkg::word_t    a,
	input  wire                       iorq,
	input  wire                       rd,
	input  wire                       wr,
	output zports_pkg::io_strobe_t    strobe,
	output zports_pkg::port_sel_t     sel,
	output logic                      porthit,
	output logic                      dataout
);
	import zports_pkg::*;

	byte_t loa;
	logic  rd_lvl;
	logic  wr_lvl;
	logic  rd_q;
	logic  rd_qq;
	logic  wr_q;
	logic  wr_qq;

	assign loa = a[7:0];

	// bus cycle levels straight from the z80 pins
	assign rd_lvl = iorq & rd;
	assign wr_lvl = iorq & wr;

	// two sample stages, strobe fires one clock after the rising sample
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			rd_q   <= 1'b0;
			rd_qq  <= 1'b0;
			wr_q   <= 1'b0;
			wr_qq  <= 1'b0;
			strobe <= '0;
		end
		else
		begin
			rd_q      <= rd_lvl;
			rd_qq     <= rd_q;
			wr_q      <= wr_lvl;
			wr_qq     <= wr_q;
			strobe.rd <= rd_q & ~rd_qq; // single pulse per held cycle
			strobe.wr <= wr_q & ~wr_qq;
		end
	end

	always_comb
	begin
		sel        = '0;
		sel.fe     = (loa == port_fe);
		sel.fd     = (loa == port_fd) && !a[15]; // a15 high is the AY, not ours
		sel.xt     = (loa == port_xt);
		sel.ide_odd = (loa == ide_hi);
		sel.kjoy   = (loa == port_kjoy);
		sel.kmouse = (loa == port_kmouse);
		sel.ide_cs1 = (loa == ide_c8);

		// every ide register port except the high byte latch
		sel.ide_even = loa inside {ide_lo, ide_30, ide_50, ide_70,
			ide_90, ide_b0, ide_d0, ide_f0, ide_c8};
	end

	// any internal port claims the cycle
	assign porthit = |sel;

	// drive the z80 data bus only on reads of our own ports
	assign dataout = porthit & rd_lvl;

endmodule

`default_nettype wire

/* hw/zports_pkg.sv */
// shared types and constants of the Z80 port block, imported by every RTL module
`default_nettype none

package zports_pkg;

	typedef logic [7:0]  byte_t;     // bus data, register bytes, page numbers
	typedef logic [15:0] word_t;     // z80 address or ide data word
	typedef logic [31:0] page_vec_t; // page 3 in top byte
	typedef logic [4:0]  fmaddr_t;
	typedef logic [3:0]  fddvirt_t;

	// low address byte of each port
	localparam byte_t port_fe     = 8'hFE;
	localparam byte_t port_fd     = 8'hFD;
	localparam byte_t port_xt     = 8'hAF;
	localparam byte_t port_kjoy   = 8'h1F;
	localparam byte_t port_kmouse = 8'hDF;

	// ide register ports, #10 low data byte and #11 high data byte
	localparam byte_t ide_lo = 8'h10;
	localparam byte_t ide_hi = 8'h11;
	localparam byte_t ide_30 = 8'h30;
	localparam byte_t ide_50 = 8'h50;
	localparam byte_t ide_70 = 8'h70;
	localparam byte_t ide_90 = 8'h90;
	localparam byte_t ide_b0 = 8'hB0;
	localparam byte_t ide_d0 = 8'hD0;
	localparam byte_t ide_f0 = 8'hF0;
	localparam byte_t ide_c8 = 8'hC8; // cs1 block

	// #nnAF register index in the high address byte
	localparam byte_t xstat        = 8'h00;
	localparam byte_t rampage_base = 8'h10; // #10 to #13
	localparam byte_t fmaddr_idx   = 8'h15;
	localparam byte_t sysconf_idx  = 8'h20;
	localparam byte_t memconf_idx  = 8'h21;
	localparam byte_t im2vect_idx  = 8'h25;
	localparam byte_t fddvirt_idx  = 8'h29;

	localparam byte_t sysconf_rst = 8'h01; // 7 MHz turbo
	localparam byte_t memconf_rst = 8'h04; // rom mapping off
	localparam byte_t im2vect_rst = 8'hFF;
	localparam byte_t page0_rst   = 8'h00;
	localparam byte_t page1_rst   = 8'h05;
	localparam byte_t page2_rst   = 8'h02;
	localparam byte_t page3_rst   = 8'h00;

	// one-cycle bus strobes on zclk
	typedef struct packed {
		logic rd;
		logic wr;
	} io_strobe_t;

	typedef struct packed {
		logic fe;
		logic fd;       // #xxFD, a15 low only
		logic xt;
		logic ide_even; // all ide ports but #11
		logic ide_odd;  // #11
		logic kjoy;
		logic kmouse;
		logic ide_cs1;  // #C8
	} port_sel_t;

	typedef struct packed {
		byte_t    sysconf;
		byte_t    memconf;
		byte_t    im2vect;
		fmaddr_t  fmaddr;
		fddvirt_t fddvirt;
	} sys_cfg_t;

endpackage

`default_nettype wire
